// File: hdl/axi_sys_pkg.sv
package axi_sys_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // Address map, each window is 256 MB and aligned to its size
    localparam logic [ADDR_W-1:0] RAM_BASE = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] RAM_END  = 32'h0FFF_FFFF;
    localparam logic [ADDR_W-1:0] DDS_BASE = 32'h2000_0000;
    localparam logic [ADDR_W-1:0] DDS_END  = 32'h2FFF_FFFF;

    // On-chip RAM, index from address bits 9:2
    localparam int RAM_WORDS = 256;
    localparam int RAM_IDX_W = $clog2(RAM_WORDS);

    // DDS sizing
    localparam int DDS_CHANNELS = 2;
    localparam int WAVE_W       = 8;

    // Response codes as on AXI
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    // DDS register offset, address bits 3:2
    typedef enum logic [1:0] {
        REG_TUNE0,
        REG_CTRL0,
        REG_TUNE1,
        REG_CTRL1
    } dds_reg_e;

    // Decoded target of one request
    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_DDS,
        SEL_NONE
    } slave_sel_e;

    // Write address and data travel together as one beat
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } wr_req_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } rd_req_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] resp;
    } wr_rsp_t;

    typedef struct packed {
        logic              valid;
        logic [1:0]        resp;
        logic [DATA_W-1:0] data;
    } rd_rsp_t;

    // Per-slave strobe, word address keeps byte-address bit numbering
    typedef struct packed {
        logic              wr_en;
        logic              rd_en;
        logic [ADDR_W-1:2] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } slave_req_t;

    typedef struct packed {
        logic              rd_valid;
        logic [DATA_W-1:0] data;
    } slave_rd_t;

    // Control view of a DDS register
    typedef struct packed {
        logic [DATA_W-3:0] rsvd;
        // 0 selects square, 1 selects sawtooth
        logic              wave_sel;
        logic              enable;
    } dds_ctrl_t;

    // Same word seen as tuning word or as control bits
    typedef union packed {
        logic [DATA_W-1:0] tune;
        dds_ctrl_t         ctrl;
    } dds_reg_u;

    typedef logic [DDS_CHANNELS-1:0][WAVE_W-1:0] wave_vec_t;

    // Replace only the bytes enabled by the strobe
    function automatic logic [DATA_W-1:0] strb_merge(
        input logic [DATA_W-1:0] old_word,
        input logic [DATA_W-1:0] new_word,
        input logic [STRB_W-1:0] strb
    );
        logic [DATA_W-1:0] merged;
        merged = old_word;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage

// File: hdl/addr_decode.sv
module addr_decode (
    input  logic                    bus_clk,
    input  logic                    arst_n,
    input  axi_sys_pkg::wr_req_t    wr_req,
    input  axi_sys_pkg::rd_req_t    rd_req,
    input  logic                    wr_busy,
    input  logic                    rd_busy,
    output logic                    wr_ready,
    output logic                    rd_ready,
    output axi_sys_pkg::slave_req_t ram_req,
    output axi_sys_pkg::slave_req_t dds_req,
    output axi_sys_pkg::slave_sel_e wr_sel,
    output axi_sys_pkg::slave_sel_e rd_sel,
    output logic                    wr_issue,
    output logic                    rd_issue
);
    import axi_sys_pkg::*;

    slave_sel_e        wr_tgt;
    slave_sel_e        rd_tgt;
    logic              wr_acc;
    logic              rd_acc;
    logic              wr_issue_q;
    logic              rd_issue_q;
    slave_sel_e        wr_sel_q;
    slave_sel_e        rd_sel_q;
    logic [ADDR_W-1:2] wr_addr_q;
    logic [DATA_W-1:0] wr_data_q;
    logic [STRB_W-1:0] wr_strb_q;
    logic [ADDR_W-1:2] rd_addr_q;

    // Windows are size aligned, so masking off the offset leaves the base
    function automatic slave_sel_e decode(input logic [ADDR_W-1:0] addr);
        slave_sel_e sel;
        if ((addr & ~(RAM_END - RAM_BASE)) == RAM_BASE) begin
            sel = SEL_RAM;
        end else if ((addr & ~(DDS_END - DDS_BASE)) == DDS_BASE) begin
            sel = SEL_DDS;
        end else begin
            sel = SEL_NONE;
        end
        return sel;
    endfunction

    // Strobe for one slave from the registered requests
    function automatic slave_req_t build_req(input slave_sel_e tgt);
        slave_req_t r;
        r.wr_en = wr_issue_q && (wr_sel_q == tgt);
        r.rd_en = rd_issue_q && (rd_sel_q == tgt);
        // Write and read never share a slave in one cycle
        r.addr  = r.wr_en ? wr_addr_q : rd_addr_q;
        r.data  = wr_data_q;
        r.strb  = wr_strb_q;
        return r;
    endfunction

    assign wr_tgt = decode(wr_req.addr);
    assign rd_tgt = decode(rd_req.addr);

    // Channel blocked from issue until its response is taken
    assign wr_ready = !wr_busy;
    // A read to the slave that takes a write this cycle waits one cycle
    assign rd_ready = !rd_busy &&
                      !(wr_acc && (wr_tgt == rd_tgt) && (wr_tgt != SEL_NONE));

    assign wr_acc = wr_req.valid && wr_ready;
    assign rd_acc = rd_req.valid && rd_ready;

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_issue_q <= 1'b0;
            rd_issue_q <= 1'b0;
            wr_sel_q   <= SEL_NONE;
            rd_sel_q   <= SEL_NONE;
        end else begin
            wr_issue_q <= wr_acc;
            rd_issue_q <= rd_acc;
            if (wr_acc) begin
                wr_sel_q <= wr_tgt;
            end
            if (rd_acc) begin
                rd_sel_q <= rd_tgt;
            end
        end
    end

    // Request payload
    always_ff @(posedge bus_clk) begin
        if (wr_acc) begin
            wr_addr_q <= wr_req.addr[ADDR_W-1:2];
            wr_data_q <= wr_req.data;
            wr_strb_q <= wr_req.strb;
        end
        if (rd_acc) begin
            rd_addr_q <= rd_req.addr[ADDR_W-1:2];
        end
    end

    always_comb begin
        ram_req = build_req(SEL_RAM);
        dds_req = build_req(SEL_DDS);
    end

    assign wr_sel   = wr_sel_q;
    assign rd_sel   = rd_sel_q;
    assign wr_issue = wr_issue_q;
    assign rd_issue = rd_issue_q;

    // One write and one read strobe at most, never both on one slave
    a_strobe_onehot: assert property (@(posedge bus_clk) disable iff (!arst_n)
        $onehot0({ram_req.wr_en, dds_req.wr_en}) && $onehot0({ram_req.rd_en, dds_req.rd_en}))
        else $error("more than one slave strobe of a kind");
    a_no_share: assert property (@(posedge bus_clk) disable iff (!arst_n)
        !(ram_req.wr_en && ram_req.rd_en) && !(dds_req.wr_en && dds_req.rd_en))
        else $error("write and read strobe on one slave");

endmodule

// File: hdl/ram_slave.sv
module ram_slave (
    input  logic                    bus_clk,
    input  logic                    arst_n,
    input  axi_sys_pkg::slave_req_t req,
    output axi_sys_pkg::slave_rd_t  rd
);
    import axi_sys_pkg::*;

    logic [DATA_W-1:0]    mem [RAM_WORDS];
    logic [RAM_IDX_W-1:0] idx;
    logic                 rd_valid_q;
    logic [DATA_W-1:0]    rd_data_q;

    // Upper address bits ignored, RAM aliases inside its window
    assign idx = req.addr[RAM_IDX_W+1:2];

    // Word storage with byte strobes
    always_ff @(posedge bus_clk) begin
        if (req.wr_en) begin
            mem[idx] <= strb_merge(mem[idx], req.data, req.strb);
        end
    end

    // Read data registered, held until the next read
    always_ff @(posedge bus_clk) begin
        if (req.rd_en) begin
            rd_data_q <= mem[idx];
        end
    end

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= req.rd_en;
        end
    end

    always_comb begin
        rd.rd_valid = rd_valid_q;
        rd.data     = rd_data_q;
    end

    // Read result one cycle after the strobe, never without one
    a_rd_latency: assert property (@(posedge bus_clk) disable iff (!arst_n)
        rd.rd_valid == $past(req.rd_en))
        else $error("RAM read latency broken");

endmodule

// File: hdl/dds_slave.sv
module dds_slave (
    input  logic                    bus_clk,
    input  logic                    arst_n,
    input  axi_sys_pkg::slave_req_t req,
    output axi_sys_pkg::slave_rd_t  rd,
    output axi_sys_pkg::wave_vec_t  wave_out
);
    import axi_sys_pkg::*;

    // Tuning and control word per channel, in offset order
    dds_reg_u          regs [2*DDS_CHANNELS];
    dds_reg_e          reg_off;
    logic              rd_valid_q;
    logic [DATA_W-1:0] rd_data_q;

    // Only bits 3:2 select a register
    assign reg_off = dds_reg_e'(req.addr[3:2]);

    // Register file, cleared so channels start disabled
    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2*DDS_CHANNELS; i++) begin
                regs[i] <= '0;
            end
        end else if (req.wr_en) begin
            regs[reg_off] <= strb_merge(regs[reg_off], req.data, req.strb);
        end
    end

    // Readback of the full stored word
    always_ff @(posedge bus_clk) begin
        if (req.rd_en) begin
            rd_data_q <= regs[reg_off];
        end
    end

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= req.rd_en;
        end
    end

    always_comb begin
        rd.rd_valid = rd_valid_q;
        rd.data     = rd_data_q;
    end

    for (genvar ch = 0; ch < DDS_CHANNELS; ch++) begin : g_chan
        dds_reg_u          tune_r;
        dds_reg_u          ctrl_r;
        logic [DATA_W-1:0] phase;

        assign tune_r = regs[2*ch];
        assign ctrl_r = regs[2*ch+1];

        // Phase accumulator
        always_ff @(posedge bus_clk or negedge arst_n) begin
            if (!arst_n) begin
                phase <= '0;
            end else if (ctrl_r.ctrl.enable) begin
                phase <= phase + tune_r.tune;
            end else begin
                // Disabled channel restarts from phase 0
                phase <= '0;
            end
        end

        // Sawtooth takes the top phase bits, square only the MSB
        assign wave_out[ch] = !ctrl_r.ctrl.enable  ? '0 :
                              ctrl_r.ctrl.wave_sel ? phase[DATA_W-1 -: WAVE_W] :
                                                     {WAVE_W{phase[DATA_W-1]}};

        // Square samples stay at the rails
        a_square_rails: assert property (@(posedge bus_clk) disable iff (!arst_n)
            !ctrl_r.ctrl.wave_sel |-> (wave_out[ch] == '0 || wave_out[ch] == '1))
            else $error("square sample off the rails on channel %0d", ch);
    end

endmodule

// File: hdl/resp_merge.sv
module resp_merge (
    input  logic                    bus_clk,
    input  logic                    arst_n,
    input  axi_sys_pkg::slave_sel_e wr_sel,
    input  axi_sys_pkg::slave_sel_e rd_sel,
    input  logic                    wr_issue,
    input  logic                    rd_issue,
    input  axi_sys_pkg::slave_rd_t  ram_rd,
    input  axi_sys_pkg::slave_rd_t  dds_rd,
    input  logic                    wr_rsp_ready,
    input  logic                    rd_rsp_ready,
    output axi_sys_pkg::wr_rsp_t    wr_rsp,
    output axi_sys_pkg::rd_rsp_t    rd_rsp,
    output logic                    wr_busy,
    output logic                    rd_busy
);
    import axi_sys_pkg::*;

    logic              wr_valid_q;
    logic              rd_valid_q;
    slave_sel_e        wr_sel_q;
    slave_sel_e        rd_sel_q;
    // High in the cycle the slave returns its data
    logic              rd_new_q;
    logic [DATA_W-1:0] rd_live;
    logic [DATA_W-1:0] rd_hold_q;

    // Data of the selected slave, zero on decode error
    always_comb begin
        case (rd_sel_q)
            SEL_RAM: rd_live = ram_rd.rd_valid ? ram_rd.data : '0;
            SEL_DDS: rd_live = dds_rd.rd_valid ? dds_rd.data : '0;
            default: rd_live = '0;
        endcase
    end

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_valid_q <= 1'b0;
            rd_valid_q <= 1'b0;
            wr_sel_q   <= SEL_NONE;
            rd_sel_q   <= SEL_NONE;
            rd_new_q   <= 1'b0;
        end else begin
            if (wr_issue) begin
                wr_valid_q <= 1'b1;
                wr_sel_q   <= wr_sel;
            end else if (wr_rsp_ready) begin
                wr_valid_q <= 1'b0;
            end
            if (rd_issue) begin
                rd_valid_q <= 1'b1;
                rd_sel_q   <= rd_sel;
            end else if (rd_rsp_ready) begin
                rd_valid_q <= 1'b0;
            end
            rd_new_q <= rd_issue;
        end
    end

    // Capture slave data so the response holds under back-pressure
    always_ff @(posedge bus_clk) begin
        if (rd_new_q) begin
            rd_hold_q <= rd_live;
        end
    end

    always_comb begin
        wr_rsp.valid = wr_valid_q;
        wr_rsp.resp  = (wr_sel_q == SEL_NONE) ? RESP_DECERR : RESP_OKAY;
        rd_rsp.valid = rd_valid_q;
        rd_rsp.resp  = (rd_sel_q == SEL_NONE) ? RESP_DECERR : RESP_OKAY;
        rd_rsp.data  = rd_new_q ? rd_live : rd_hold_q;
    end

    // Busy from issue until the response is taken
    assign wr_busy = wr_issue || wr_valid_q;
    assign rd_busy = rd_issue || rd_valid_q;

    a_wr_hold: assert property (@(posedge bus_clk) disable iff (!arst_n)
        wr_rsp.valid && !wr_rsp_ready |=> wr_rsp.valid && $stable(wr_rsp))
        else $error("write response changed while stalled");
    a_rd_hold: assert property (@(posedge bus_clk) disable iff (!arst_n)
        rd_rsp.valid && !rd_rsp_ready |=> rd_rsp.valid && $stable(rd_rsp))
        else $error("read response changed while stalled");

endmodule

// File: hdl/axi_sys_top.sv
module axi_sys_top (
    input  logic                   bus_clk,
    input  logic                   arst_n,
    input  axi_sys_pkg::wr_req_t   wr_req,
    input  axi_sys_pkg::rd_req_t   rd_req,
    input  logic                   wr_rsp_ready,
    input  logic                   rd_rsp_ready,
    output logic                   wr_ready,
    output logic                   rd_ready,
    output axi_sys_pkg::wr_rsp_t   wr_rsp,
    output axi_sys_pkg::rd_rsp_t   rd_rsp,
    output axi_sys_pkg::wave_vec_t wave_out
);
    import axi_sys_pkg::*;

    // Decoder to slaves
    slave_req_t ram_req;
    slave_req_t dds_req;
    // Slaves to merger
    slave_rd_t  ram_rd;
    slave_rd_t  dds_rd;
    // Decoder and merger handshake
    slave_sel_e wr_sel;
    slave_sel_e rd_sel;
    logic       wr_issue;
    logic       rd_issue;
    logic       wr_busy;
    logic       rd_busy;

    addr_decode u_addr_decode (
        .bus_clk  (bus_clk),
        .arst_n   (arst_n),
        .wr_req   (wr_req),
        .rd_req   (rd_req),
        .wr_busy  (wr_busy),
        .rd_busy  (rd_busy),
        .wr_ready (wr_ready),
        .rd_ready (rd_ready),
        .ram_req  (ram_req),
        .dds_req  (dds_req),
        .wr_sel   (wr_sel),
        .rd_sel   (rd_sel),
        .wr_issue (wr_issue),
        .rd_issue (rd_issue)
    );

    // Slot 0 of the map
    ram_slave u_ram_slave (
        .bus_clk (bus_clk),
        .arst_n  (arst_n),
        .req     (ram_req),
        .rd      (ram_rd)
    );

    // Slot 2 of the map, runs on the bus clock
    dds_slave u_dds_slave (
        .bus_clk  (bus_clk),
        .arst_n   (arst_n),
        .req      (dds_req),
        .rd       (dds_rd),
        .wave_out (wave_out)
    );

    resp_merge u_resp_merge (
        .bus_clk      (bus_clk),
        .arst_n       (arst_n),
        .wr_sel       (wr_sel),
        .rd_sel       (rd_sel),
        .wr_issue     (wr_issue),
        .rd_issue     (rd_issue),
        .ram_rd       (ram_rd),
        .dds_rd       (dds_rd),
        .wr_rsp_ready (wr_rsp_ready),
        .rd_rsp_ready (rd_rsp_ready),
        .wr_rsp       (wr_rsp),
        .rd_rsp       (rd_rsp),
        .wr_busy      (wr_busy),
        .rd_busy      (rd_busy)
    );

endmodule

// File: sim/tb_axi_sys.sv
module tb_axi_sys;
    timeunit 1ns;
    timeprecision 100ps;
    import axi_sys_pkg::*;

    // Operation budget, the watchdog is sized from it
    localparam int N_FILL          = RAM_WORDS;
    localparam int N_RAND          = 300;
    localparam int N_OPS           = N_FILL + N_RAND + 40;
    localparam int WATCHDOG_CYCLES = N_OPS * 20 + 1000;

    logic      bus_clk;
    logic      arst_n;
    wr_req_t   wr_req;
    rd_req_t   rd_req;
    logic      wr_rsp_ready;
    logic      rd_rsp_ready;
    logic      wr_ready;
    logic      rd_ready;
    wr_rsp_t   wr_rsp;
    rd_rsp_t   rd_rsp;
    wave_vec_t wave_out;

    logic [31:0] lfsr = 32'h4665cf05;
    // Reference copies of RAM words and DDS registers
    logic [31:0] ram_model [RAM_WORDS];
    logic [31:0] dds_model [4];
    logic [1:0]  exp_wr_resp;
    logic [1:0]  exp_rd_resp;
    logic [31:0] exp_rd_data;
    // Wave samples of the last two cycles, for the sawtooth step
    wave_vec_t   wave_seen;
    wave_vec_t   wave_prev;
    // Cycles since the last DDS register write
    int          dds_quiet = 0;
    int          errors = 0;
    int          n_wr = 0;
    int          n_rd = 0;
    logic        wr_acc;
    logic        rd_acc;

    axi_sys_top DUT (
        .bus_clk      (bus_clk),
        .arst_n       (arst_n),
        .wr_req       (wr_req),
        .rd_req       (rd_req),
        .wr_rsp_ready (wr_rsp_ready),
        .rd_rsp_ready (rd_rsp_ready),
        .wr_ready     (wr_ready),
        .rd_ready     (rd_ready),
        .wr_rsp       (wr_rsp),
        .rd_rsp       (rd_rsp),
        .wave_out     (wave_out)
    );

    assign wr_acc = wr_req.valid && wr_ready;
    assign rd_acc = rd_req.valid && rd_ready;

    initial begin
        bus_clk = 1'b0;
        forever #5 bus_clk = ~bus_clk;
    end

    // Galois form, polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = next_lfsr(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Top nibble picks the 256 MB slot
    function automatic slave_sel_e window_of(input logic [31:0] addr);
        if (addr[31:28] == RAM_BASE[31:28]) return SEL_RAM;
        if (addr[31:28] == DDS_BASE[31:28]) return SEL_DDS;
        return SEL_NONE;
    endfunction

    function automatic logic [31:0] apply_strobe(input logic [31:0] old_w, input logic [31:0] new_w,
                                                 input logic [3:0] strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    // Anywhere in the RAM window, upper bits test the aliasing
    function automatic logic [31:0] ram_addr();
        return rand_bits(26) << 2;
    endfunction

    function automatic logic [31:0] unmapped_addr();
        logic [3:0] slot;
        slot = 4'(rand_bits(4));
        if (slot == 4'h0 || slot == 4'h2) begin
            slot = slot + 4'h1;
        end
        return {slot, 28'(rand_bits(28))};
    endfunction

    // Model follows every accepted request, sampled mid-cycle where inputs are stable
    always @(negedge bus_clk) begin : track_model
        if (dds_quiet < 1000) begin
            dds_quiet = dds_quiet + 1;
        end
        wave_prev = wave_seen;
        wave_seen = wave_out;
        if (!arst_n) begin
            for (int i = 0; i < 4; i++) begin
                dds_model[i] = '0;
            end
            exp_wr_resp = RESP_OKAY;
            exp_rd_resp = RESP_OKAY;
            exp_rd_data = '0;
        end else begin
            if (wr_acc) begin
                n_wr = n_wr + 1;
                case (window_of(wr_req.addr))
                    SEL_RAM: ram_model[wr_req.addr[9:2]] =
                        apply_strobe(ram_model[wr_req.addr[9:2]], wr_req.data, wr_req.strb);
                    SEL_DDS: begin
                        dds_model[wr_req.addr[3:2]] =
                            apply_strobe(dds_model[wr_req.addr[3:2]], wr_req.data, wr_req.strb);
                        dds_quiet = 0;
                    end
                    default: ;
                endcase
                exp_wr_resp = (window_of(wr_req.addr) == SEL_NONE) ? RESP_DECERR : RESP_OKAY;
            end
            if (rd_acc) begin
                n_rd = n_rd + 1;
                case (window_of(rd_req.addr))
                    SEL_RAM: exp_rd_data = ram_model[rd_req.addr[9:2]];
                    SEL_DDS: exp_rd_data = dds_model[rd_req.addr[3:2]];
                    default: exp_rd_data = '0;
                endcase
                exp_rd_resp = (window_of(rd_req.addr) == SEL_NONE) ? RESP_DECERR : RESP_OKAY;
            end
        end
    end

    // Out of reset with both channels open
    a_reset_state: assert property (@(posedge bus_clk)
        $rose(arst_n) |-> wr_ready && rd_ready && !wr_rsp.valid && !rd_rsp.valid)
        else begin
            errors = errors + 1;
            $display("%0t: ready low or response valid right after reset", $time);
        end

    // Response rises exactly two cycles after acceptance and at no other time
    a_wr_latency: assert property (@(posedge bus_clk) disable iff (!arst_n)
        $past(wr_acc, 2) == (wr_rsp.valid && !$past(wr_rsp.valid)))
        else begin
            errors = errors + 1;
            $display("%0t: write response not valid exactly 2 cycles after accept", $time);
        end
    a_rd_latency: assert property (@(posedge bus_clk) disable iff (!arst_n)
        $past(rd_acc, 2) == (rd_rsp.valid && !$past(rd_rsp.valid)))
        else begin
            errors = errors + 1;
            $display("%0t: read response not valid exactly 2 cycles after accept", $time);
        end

    a_wr_hold: assert property (@(posedge bus_clk) disable iff (!arst_n)
        wr_rsp.valid && !wr_rsp_ready |=> $stable(wr_rsp))
        else begin
            errors = errors + 1;
            $display("%0t: write response changed while stalled", $time);
        end
    a_rd_hold: assert property (@(posedge bus_clk) disable iff (!arst_n)
        rd_rsp.valid && !rd_rsp_ready |=> $stable(rd_rsp))
        else begin
            errors = errors + 1;
            $display("%0t: read response changed while stalled", $time);
        end

    a_wr_resp: assert property (@(posedge bus_clk) disable iff (!arst_n)
        wr_rsp.valid |-> wr_rsp.resp == exp_wr_resp)
        else begin
            errors = errors + 1;
            $display("MISMATCH %0t wr_rsp.resp expected %0d actual %0d",
                     $time, exp_wr_resp, $sampled(wr_rsp.resp));
        end
    a_rd_resp: assert property (@(posedge bus_clk) disable iff (!arst_n)
        rd_rsp.valid |-> rd_rsp.resp == exp_rd_resp)
        else begin
            errors = errors + 1;
            $display("MISMATCH %0t rd_rsp.resp expected %0d actual %0d",
                     $time, exp_rd_resp, $sampled(rd_rsp.resp));
        end
    // Covers RAM words, DDS readback and zero data on decode error
    a_rd_data: assert property (@(posedge bus_clk) disable iff (!arst_n)
        rd_rsp.valid |-> rd_rsp.data == exp_rd_data)
        else begin
            errors = errors + 1;
            $display("MISMATCH %0t rd_rsp.data expected %h actual %h",
                     $time, exp_rd_data, $sampled(rd_rsp.data));
        end

    // Wave checks only once register writes have settled
    for (genvar ch = 0; ch < DDS_CHANNELS; ch++) begin : g_wave
        a_off: assert property (@(posedge bus_clk) disable iff (!arst_n)
            dds_quiet >= 4 && !dds_model[2*ch+1][0] |-> wave_out[ch] == 8'h00)
            else begin
                errors = errors + 1;
                $display("MISMATCH %0t wave_out[%0d] expected 00 actual %h",
                         $time, ch, $sampled(wave_out[ch]));
            end
        a_square: assert property (@(posedge bus_clk) disable iff (!arst_n)
            dds_quiet >= 4 && dds_model[2*ch+1][0] && !dds_model[2*ch+1][1]
            |-> wave_out[ch] == 8'h00 || wave_out[ch] == 8'hFF)
            else begin
                errors = errors + 1;
                $display("%0t: square sample %h on channel %0d is off the rails",
                         $time, $sampled(wave_out[ch]), ch);
            end
        // Tuning word 2^24 moves the top byte by one per cycle
        a_saw_step: assert property (@(posedge bus_clk) disable iff (!arst_n)
            dds_quiet >= 4 && dds_model[2*ch+1][0] && dds_model[2*ch+1][1] &&
            dds_model[2*ch] == 32'h0100_0000 |-> wave_out[ch] == 8'(wave_prev[ch] + 8'd1))
            else begin
                errors = errors + 1;
                $display("MISMATCH %0t wave_out[%0d] expected %h actual %h", $time, ch,
                         8'(wave_prev[ch] + 8'd1), $sampled(wave_out[ch]));
            end
    end

    // Just after a rising edge, with random response stalls
    task automatic next_cycle();
        @(posedge bus_clk);
        #1;
        wr_rsp_ready = (rand_bits(2) != 0);
        rd_rsp_ready = (rand_bits(2) != 0);
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    // Hold each request until accepted, both channels may run together
    task automatic issue(input logic do_wr, input logic [31:0] waddr, input logic [31:0] wdata,
                         input logic [3:0] wstrb, input logic do_rd, input logic [31:0] raddr);
        logic wr_pend;
        logic rd_pend;
        logic wr_take;
        logic rd_take;
        wr_pend = do_wr;
        rd_pend = do_rd;
        wr_req  = '{valid: do_wr, addr: waddr, data: wdata, strb: wstrb};
        rd_req  = '{valid: do_rd, addr: raddr};
        while (wr_pend || rd_pend) begin
            @(negedge bus_clk);
            wr_take = wr_pend && wr_ready;
            rd_take = rd_pend && rd_ready;
            next_cycle();
            if (wr_take) begin
                wr_req.valid = 1'b0;
                wr_pend = 1'b0;
            end
            if (rd_take) begin
                rd_req.valid = 1'b0;
                rd_pend = 1'b0;
            end
        end
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        issue(1'b1, addr, data, strb, 1'b0, '0);
    endtask

    task automatic read_word(input logic [31:0] addr);
        issue(1'b0, '0, '0, '0, 1'b1, addr);
    endtask

    task automatic random_op();
        logic [2:0]  kind;
        logic [31:0] a;
        kind = 3'(rand_bits(3));
        a    = ram_addr();
        case (kind)
            3'd0, 3'd1: write_word(a, rand_bits(32), 4'(rand_bits(4)));
            3'd2, 3'd3: read_word(a);
            // Same word on both channels, the read waits for the write
            3'd4: issue(1'b1, a, rand_bits(32), 4'(rand_bits(4)), 1'b1, a);
            3'd5: issue(1'b1, a, rand_bits(32), 4'hF, 1'b1, DDS_BASE | (rand_bits(2) << 2));
            3'd6: write_word(unmapped_addr(), rand_bits(32), 4'hF);
            default: read_word(unmapped_addr());
        endcase
    endtask

    task automatic read_dds_regs();
        for (int off = 0; off < 4; off++) begin
            read_word(DDS_BASE + 32'(off * 4));
        end
    endtask

    task automatic dds_sequence();
        // Channel 0 sawtooth at one step per cycle
        write_word(DDS_BASE + 32'h0, 32'h0100_0000, 4'hF);
        write_word(DDS_BASE + 32'h4, 32'h0000_0003, 4'hF);
        // Channel 1 square with a random tuning word, partly rewritten
        write_word(DDS_BASE + 32'h8, rand_bits(32), 4'hF);
        write_word(DDS_BASE + 32'h8, rand_bits(32), 4'(rand_bits(4)));
        write_word(DDS_BASE + 32'hC, 32'h0000_0001, 4'b0001);
        read_dds_regs();
        idle(300);
        // Low byte only, upper bytes must survive
        write_word(DDS_BASE + 32'hC, 32'hFFFF_FF00, 4'b0001);
        write_word(DDS_BASE + 32'h4, 32'h0000_0001, 4'hF);
        idle(40);
        read_dds_regs();
        write_word(DDS_BASE + 32'h4, 32'h0000_0000, 4'hF);
        idle(20);
        read_dds_regs();
    endtask

    // Both channels open again means every response was taken
    task automatic drain();
        logic bus_idle;
        bus_idle = 1'b0;
        while (!bus_idle) begin
            @(negedge bus_clk);
            bus_idle = wr_ready && rd_ready;
            next_cycle();
        end
        idle(4);
    endtask

    initial begin
        wr_req       = '0;
        rd_req       = '0;
        wr_rsp_ready = 1'b0;
        rd_rsp_ready = 1'b0;
        arst_n       = 1'b0;
        repeat (3) @(posedge bus_clk);
        #1;
        arst_n = 1'b1;
        next_cycle();
        // Every RAM word gets a known value first
        for (int i = 0; i < N_FILL; i++) begin
            write_word(32'(i) << 2, rand_bits(32), 4'hF);
        end
        for (int i = 0; i < N_RAND; i++) begin
            random_op();
        end
        dds_sequence();
        drain();
        $display("writes=%0d reads=%0d errors=%0d", n_wr, n_rd, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge bus_clk);
        $display("watchdog expired after %0d cycles, writes=%0d reads=%0d errors=%0d",
                 WATCHDOG_CYCLES, n_wr, n_rd, errors);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: src.f
hdl/axi_sys_pkg.sv
hdl/addr_decode.sv
hdl/ram_slave.sv
hdl/dds_slave.sv
hdl/resp_merge.sv
hdl/axi_sys_top.sv
sim/tb_axi_sys.sv

// File: Makefile
TOP := tb_axi_sys

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log for the pass line"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@grep -qxF '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log
